// ==== bench/exeStageTb.sv ====
`default_nettype none

module exeStageTb import rv32Pkg::*, trapPkg::*;
();

	typedef struct packed {
		word_t opA, opB, pc, bImm, jImm, uImm;
		csrImm_t csrImm;
		word_t csrData;
		regAddr_t rd;
		logic we;
		aluOp_t aluOp;
		wbSel_t wbSel;
		csrOp_t csrOp;
		csrAddr_t csrAddr;
		logic csrWe;
		logic isBranch, branchNe, isJal, isJalr;
		logic ecall, illegal, mret, sret, uret;
	} issue_t;

	// pending lines and enables in the order mTimer .. sEie
	typedef struct packed {
		logic mTimer, sTimer, extIrq;
		logic mTie, sTie, mEie, sEie;
		mode_t curMode;
	} irq_t;

	typedef struct packed {
		logic branchClass;
		logic bjTaken;
		word_t target;
		word_t wbData;
		regAddr_t rd;
		logic we;
		word_t pc;
		word_t csrWb;
		csrAddr_t csrWbAddr;
		logic csrWe;
		logic ecall, illegal, mret, sret, uret;
	} expect_t;

	logic clk = 1'b0;
	logic nrst;
	issue_t cur, nxt;	// cur drives the DUT
	irq_t irqCur, irqNxt;
	expect_t s5, s6;	// model of the two pipeline slots
	string n5, n6;

	logic bjTaken, weOut, csrWeOut, mretOut, sretOut, uretOut, exception;
	word_t target, wbData, pcOut, csrWb;
	regAddr_t rdOut;
	csrAddr_t csrWbAddr;
	cause_t cause;

	always #50 clk = ~clk;

	exeStage uut (
		.clk, .nrst,
		.opA(cur.opA), .opB(cur.opB), .pc(cur.pc),
		.bImm(cur.bImm), .jImm(cur.jImm), .uImm(cur.uImm),
		.csrImm(cur.csrImm), .csrData(cur.csrData),
		.rd(cur.rd), .we(cur.we), .aluOp(cur.aluOp), .wbSel(cur.wbSel),
		.csrOp(cur.csrOp), .csrAddr(cur.csrAddr), .csrWe(cur.csrWe),
		.isBranch(cur.isBranch), .branchNe(cur.branchNe),
		.isJal(cur.isJal), .isJalr(cur.isJalr),
		.ecall(cur.ecall), .illegal(cur.illegal),
		.mret(cur.mret), .sret(cur.sret), .uret(cur.uret),
		.mTimer(irqCur.mTimer), .sTimer(irqCur.sTimer), .extIrq(irqCur.extIrq),
		.mTie(irqCur.mTie), .sTie(irqCur.sTie), .mEie(irqCur.mEie), .sEie(irqCur.sEie),
		.curMode(irqCur.curMode),
		.bjTaken, .target, .wbData, .rdOut, .weOut, .pcOut,
		.csrWb, .csrWbAddr, .csrWeOut,
		.mretOut, .sretOut, .uretOut,
		.exception, .cause
	);

	function automatic word_t aluModel(aluOp_t op, word_t a, word_t b);
		logic [4:0] sh;
		sh = b[4:0];
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_SLL: return a << sh;
			ALU_SLT, ALU_LT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLTU, ALU_LTU: return (a < b) ? 32'd1 : 32'd0;
			ALU_XOR: return a ^ b;
			ALU_SRL: return a >> sh;
			ALU_SRA: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);	// sign fill
			ALU_OR: return a | b;
			ALU_AND: return a & b;
			ALU_EQ: return (a == b) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic word_t csrModel(csrOp_t op, word_t rs1, csrImm_t imm, word_t old);
		word_t src;
		src = (op == CSR_RWI || op == CSR_RSI || op == CSR_RCI) ? {27'd0, imm} : rs1;
		case (op)
			CSR_RW, CSR_RWI: return src;
			CSR_RS, CSR_RSI: return old | src;
			CSR_RC, CSR_RCI: return old & ~src;
			default: return old;
		endcase
	endfunction

	function automatic expect_t expectOf(issue_t i);
		expect_t e;
		logic cond;
		e = '0;
		case (i.aluOp)
			ALU_EQ: cond = (i.opA == i.opB);
			ALU_LT: cond = ($signed(i.opA) < $signed(i.opB));
			ALU_LTU: cond = (i.opA < i.opB);
			default: cond = 1'b0;
		endcase
		if (i.aluOp == ALU_EQ || i.aluOp == ALU_LT || i.aluOp == ALU_LTU)
			cond = cond ^ i.branchNe;	// bne, bge, bgeu
		e.branchClass = i.isBranch || i.isJal || i.isJalr;
		e.bjTaken = (i.isBranch && cond) || i.isJal || i.isJalr;
		if (i.isJalr)
			e.target = (i.opA + i.opB) & 32'hffff_fffe;
		else if (i.isJal)
			e.target = i.pc + i.jImm;
		else
			e.target = i.pc + i.bImm;
		case (i.wbSel)
			WB_ALU: e.wbData = aluModel(i.aluOp, i.opA, i.opB);
			WB_LINK: e.wbData = i.pc + 32'd4;
			WB_UIMM: e.wbData = i.uImm;
			WB_AUIPC: e.wbData = i.pc + i.uImm;
			WB_CSR: e.wbData = i.csrData;
			default: e.wbData = '0;
		endcase
		e.rd = i.rd;
		e.we = i.we;
		e.pc = i.pc;
		e.csrWb = csrModel(i.csrOp, i.opA, i.csrImm, i.csrData);
		e.csrWbAddr = i.csrAddr;
		e.csrWe = i.csrWe;
		{e.ecall, e.illegal, e.mret, e.sret, e.uret} = {i.ecall, i.illegal, i.mret, i.sret, i.uret};
		return e;
	endfunction

	// pc only survives a flush at the commit register
	function automatic expect_t killEntry(expect_t e, logic inLatch);
		expect_t k;
		k = '0;
		k.pc = inLatch ? 32'd0 : e.pc;
		return k;
	endfunction

	// {exception, cause}
	function automatic logic [32:0] trapModel(irq_t q, expect_t s);
		logic sOk, mt, st, me, se, irq;
		cause_t c;
		sOk = (q.curMode == MODE_U) || (q.curMode == MODE_S);
		mt = q.mTie && q.mTimer;
		st = sOk && q.sTie && q.sTimer;
		me = q.mEie && q.extIrq;
		se = sOk && q.sEie && q.extIrq;
		irq = mt || st || me || se;
		if (me)
			c = CAUSE_M_EXT;
		else if (se)
			c = CAUSE_S_EXT;
		else if (mt)
			c = CAUSE_M_TIMER;
		else if (st)
			c = CAUSE_S_TIMER;
		else if (s.ecall)
			c = CAUSE_U_CALL + cause_t'(q.curMode);
		else if (s.illegal)
			c = CAUSE_ILLEGAL;
		else
			c = '0;
		if (irq)
			c = c | (cause_t'(1) << CAUSE_INT_BIT);
		return {irq || s.ecall || s.illegal || s.mret || s.sret || s.uret, c};
	endfunction

	task automatic stopWithFailure();
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(string test, string field, word_t exp, word_t got);
		assert (got === exp)
		else
		begin
			$display("Error in %s, %s expected %h actual %h", test, field, exp, got);
			stopWithFailure();
		end
	endtask

	// check the outputs of both slots, then drive nxt for the next cycle
	task automatic step(string name);
		logic [32:0] trapExp;
		logic [32:0] flushNext;
		string tn;
		@(negedge clk);
		checkValue(n5, "bjTaken", 32'(s5.bjTaken), 32'(bjTaken));
		if (s5.branchClass)
			checkValue(n5, "target", s5.target, target);
		checkValue(n6, "wbData", s6.wbData, wbData);
		checkValue(n6, "rd", 32'(s6.rd), 32'(rdOut));
		checkValue(n6, "we", 32'(s6.we), 32'(weOut));
		checkValue(n6, "pcOut", s6.pc, pcOut);
		checkValue(n6, "csrWb", s6.csrWb, csrWb);
		checkValue(n6, "csrWbAddr", 32'(s6.csrWbAddr), 32'(csrWbAddr));
		checkValue(n6, "csrWe", 32'(s6.csrWe), 32'(csrWeOut));
		checkValue(n6, "returns", 32'({s6.mret, s6.sret, s6.uret}),
			32'({mretOut, sretOut, uretOut}));
		trapExp = trapModel(irqCur, s6);
		tn = $sformatf("%s at commit, %s at issue", n6, n5);
		checkValue(tn, "exception", 32'(trapExp[32]), 32'(exception));
		checkValue(tn, "cause", trapExp[31:0], cause);
		flushNext = trapModel(irqNxt, s6);	// lines seen at the coming rising edge
		s6 = flushNext[32] ? killEntry(s5, 1'b0) : s5;
		n6 = n5;
		s5 = flushNext[32] ? killEntry(expectOf(nxt), 1'b1) : expectOf(nxt);
		n5 = name;
		cur = nxt;
		irqCur = irqNxt;
	endtask

	function automatic issue_t randomAdd();
		issue_t i;
		i = '0;
		i.opA = $urandom;
		i.opB = $urandom;
		i.pc = $urandom & 32'hffff_fffc;
		i.rd = regAddr_t'($urandom) | 5'd1;
		i.we = 1'b1;
		return i;
	endfunction

	// trap, two shadow instructions that must not write, then drain
	task automatic runTrap(string name, issue_t t);
		nxt = t;
		step(name);
		nxt = randomAdd();
		step({name, " shadow 1"});
		nxt = randomAdd();
		step({name, " shadow 2"});
		nxt = '0;
		repeat (2) step({name, " drain"});
	endtask

	task automatic applyIrq(string name, logic [6:0] lines, mode_t m);
		irqNxt = irq_t'({lines, m});
		nxt = '0;
		step(name);
	endtask

	task automatic aluTests();
		for (int op = 0; op <= 12; op++)
		begin
			repeat (4)
			begin
				nxt = randomAdd();
				nxt.aluOp = aluOp_t'(op);
				step($sformatf("alu op %0d", op));
			end
		end
	endtask

	task automatic upperTests();
		nxt = randomAdd();
		nxt.uImm = $urandom & 32'hffff_f000;
		nxt.wbSel = WB_UIMM;
		step("lui");
		nxt = randomAdd();
		nxt.uImm = $urandom & 32'hffff_f000;
		nxt.wbSel = WB_AUIPC;
		step("auipc");
		nxt = randomAdd();
		nxt.jImm = $urandom & 32'hffff_fffe;
		nxt.isJal = 1'b1;
		nxt.wbSel = WB_LINK;
		step("jal");
		nxt = randomAdd();
		nxt.isJalr = 1'b1;
		nxt.wbSel = WB_LINK;
		step("jalr");
	endtask

	task automatic branchTests();
		word_t pa [4];
		word_t pb [4];
		pa[0] = $urandom;
		pb[0] = pa[0];	// equal
		pa[1] = $urandom;
		pb[1] = pa[1] ^ 32'd1;	// unequal
		pa[2] = 32'hffff_fffb;
		pb[2] = 32'd3;	// signed and unsigned disagree
		pa[3] = 32'd3;
		pb[3] = 32'h8000_0000;
		for (int p = 0; p < 4; p++)
		begin
			for (int op = 10; op <= 12; op++)
			begin
				for (int ne = 0; ne < 2; ne++)
				begin
					nxt = '0;
					nxt.opA = pa[p];
					nxt.opB = pb[p];
					nxt.pc = $urandom & 32'hffff_fffc;
					nxt.bImm = $urandom & 32'hffff_fffe;
					nxt.aluOp = aluOp_t'(op);
					nxt.branchNe = ne[0];
					nxt.isBranch = 1'b1;
					step($sformatf("branch pair %0d op %0d ne %0d", p, op, ne));
				end
			end
		end
		nxt = randomAdd();
		nxt.aluOp = ALU_EQ;
		step("compare without branch");
	endtask

	task automatic csrTests();
		csrOp_t ops [6];
		ops = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};
		foreach (ops[k])
		begin
			nxt = randomAdd();
			nxt.csrOp = ops[k];
			nxt.csrData = $urandom;
			nxt.csrImm = csrImm_t'($urandom);
			nxt.csrAddr = csrAddr_t'($urandom);
			nxt.csrWe = 1'b1;
			nxt.wbSel = WB_CSR;
			step($sformatf("csr op %0d", ops[k]));
		end
	endtask

	task automatic trapTests();
		issue_t t;
		mode_t modes [3];
		modes = '{MODE_U, MODE_S, MODE_M};
		foreach (modes[k])
		begin
			irqNxt = '0;
			irqNxt.curMode = modes[k];
			t = '0;
			t.ecall = 1'b1;
			t.pc = $urandom & 32'hffff_fffc;
			runTrap($sformatf("ecall mode %0d", modes[k]), t);
		end
		t = '0;
		t.illegal = 1'b1;
		runTrap("illegal", t);
		t = '0;
		t.mret = 1'b1;
		runTrap("mret", t);
		t = '0;
		t.sret = 1'b1;
		runTrap("sret", t);
		t = '0;
		t.uret = 1'b1;
		runTrap("uret", t);
	endtask

	task automatic irqTests();
		mode_t modes [3];
		modes = '{MODE_U, MODE_S, MODE_M};
		applyIrq("all pending and enabled", 7'b111_1111, MODE_S);
		applyIrq("s ext only", 7'b001_0001, MODE_S);
		applyIrq("s ext over m timer", 7'b101_1001, MODE_U);
		applyIrq("m timer over s timer", 7'b110_1100, MODE_S);
		applyIrq("s timer", 7'b010_0100, MODE_U);
		applyIrq("s timer in m mode", 7'b010_0100, MODE_M);
		applyIrq("s ext in m mode", 7'b001_0001, MODE_M);
		applyIrq("nothing enabled", 7'b111_0000, MODE_U);
		repeat (24)
			applyIrq("random irq mix", 7'($urandom), modes[$urandom % 3]);
		applyIrq("irq cleared", 7'd0, MODE_M);
	endtask

	initial
	begin
		void'($urandom(32'h47e5));
		nrst = 1'b0;
		cur = '0;
		nxt = '0;
		irqCur = '0;
		irqNxt = '0;
		s5 = '0;
		s6 = '0;
		n5 = "reset";
		n6 = "reset";
		repeat (10) @(negedge clk);
		nrst = 1'b1;
		aluTests();
		upperTests();
		branchTests();
		csrTests();
		trapTests();
		irqTests();
		nxt = '0;
		irqNxt = '0;
		repeat (3) step("final drain");
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/exeStage_checker.sv ====
`default_nettype none

module exeStage_checker import rv32Pkg::*, trapPkg::*;
(
	input logic clk,
	input logic nrst,
	input logic weOut, csrWeOut,
	input logic exception,
	input logic bjTaken,
	input logic isBranchReg, isJalReg, isJalrReg,	// stage-5 branch class
	input cause_t cause,
	input logic mTimer, sTimer, extIrq,
	input logic mTie, sTie, mEie, sEie
);

	logic anyEnabled;

	// mode gating only narrows this further
	assign anyEnabled = (mTie && mTimer) || (sTie && sTimer) || ((mEie || sEie) && extIrq);

	flushKillsWrite: assert property (
		@(posedge clk) disable iff (!nrst) exception |=> !weOut
	) else $error("register write enable high in the cycle after an exception");

	quietAfterReset: assert property (
		@(posedge clk) $rose(nrst) |-> (!weOut && !csrWeOut)
	) else $error("write enables not low right after reset release");

	noStrayTaken: assert property (
		@(posedge clk) disable iff (!nrst)
		!(isBranchReg || isJalReg || isJalrReg) |-> !bjTaken
	) else $error("taken flag high for an instruction that is not a branch or jump");

	intBitNeedsIrq: assert property (
		@(posedge clk) disable iff (!nrst) cause[CAUSE_INT_BIT] |-> anyEnabled
	) else $error("interrupt bit set in cause without an enabled pending interrupt");

endmodule

bind exeStage exeStage_checker timingChecks (
	.clk, .nrst,
	.weOut, .csrWeOut,
	.exception, .bjTaken,
	.isBranchReg, .isJalReg, .isJalrReg,
	.cause,
	.mTimer, .sTimer, .extIrq,
	.mTie, .sTie, .mEie, .sEie
);

`default_nettype wire

// ==== exeStage.f ====
verilog/rv32Pkg.sv
verilog/trapPkg.sv
verilog/exeIssueLatch.sv
verilog/exeAlu.sv
verilog/csrModify.sv
verilog/trapDetect.sv
verilog/exeCommit.sv
verilog/exeStage.sv
bench/exeStage_checker.sv
bench/exeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exeStage testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log
: > "$log"

verilator --binary --assert --timing --top-module exeStageTb \
	-f exeStage.f -o exeStageSim >> "$log" 2>&1
if [ $? -ne 0 ]; then
	echo "Finished with errors" >> "$log"
else
	./obj_dir/exeStageSim >> "$log" 2>&1
	if [ $? -ne 0 ]; then
		echo "Finished with errors" >> "$log"
	fi
fi

cat "$log"
if grep -q "Finished with errors" "$log"; then
	exit 1
fi
exit 0

// ==== verilog/csrModify.sv ====
`default_nettype none

module csrModify import rv32Pkg::*;
(
	input csrOp_t csrOp,
	input word_t rs1Val,
	input csrImm_t csrImm,
	input word_t csrOld,	// current csr contents
	output word_t csrNew
);

	word_t immExt;

	assign immExt = word_t'(csrImm);	// zero extended uimm

	always_comb
	begin
		case (csrOp)
			CSR_RW: csrNew = rs1Val;
			CSR_RS: csrNew = csrOld | rs1Val;
			CSR_RC: csrNew = csrOld & ~rs1Val;
			CSR_RWI: csrNew = immExt;
			CSR_RSI: csrNew = csrOld | immExt;
			CSR_RCI: csrNew = csrOld & ~immExt;
			default: csrNew = csrOld;	// not a csr op, leave it
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/exeAlu.sv ====
`default_nettype none

module exeAlu import rv32Pkg::*;
(
	input aluOp_t aluOp,
	input word_t opA, opB,
	input word_t pc, bImm, jImm,
	input logic isBranch,
	input logic branchNe,	// bne, bge, bgeu
	input logic isJal, isJalr,
	output word_t aluRes,
	output logic bjTaken,
	output word_t target
);

	logic [4:0] shamt;
	logic isCmp;
	logic cond;
	word_t jalrSum;

	assign shamt = opB[4:0];

	always_comb
	begin
		case (aluOp)
			ALU_ADD: aluRes = opA + opB;
			ALU_SUB: aluRes = opA - opB;
			ALU_SLL: aluRes = opA << shamt;
			ALU_SLT, ALU_LT: aluRes = word_t'($signed(opA) < $signed(opB));
			ALU_SLTU, ALU_LTU: aluRes = word_t'(opA < opB);
			ALU_XOR: aluRes = opA ^ opB;
			ALU_SRL: aluRes = opA >> shamt;
			ALU_SRA: aluRes = word_t'($signed(opA) >>> shamt);
			ALU_OR: aluRes = opA | opB;
			ALU_AND: aluRes = opA & opB;
			ALU_EQ: aluRes = word_t'(opA == opB);
			default: aluRes = '0;
		endcase
	end

	// only the compare codes give a branch condition
	assign isCmp = (aluOp == ALU_EQ) || (aluOp == ALU_LT) || (aluOp == ALU_LTU);
	assign cond = isCmp && (aluRes[0] ^ branchNe);

	assign bjTaken = (isBranch && cond) || isJal || isJalr;

	assign jalrSum = opA + opB;

	always_comb
	begin
		if (isJalr)
			target = {jalrSum[31:1], 1'b0};	// lsb dropped per spec
		else if (isJal)
			target = pc + jImm;
		else
			target = pc + bImm;
	end

endmodule

`default_nettype wire

// ==== verilog/exeCommit.sv ====
`default_nettype none

module exeCommit import rv32Pkg::*, trapPkg::*;
(
	input logic clk,
	input logic nrst,
	input logic flush,
	input regAddr_t rdReg,
	input logic weReg,
	input wbSel_t wbSelReg,
	input word_t pcReg, uImmReg,
	input csrAddr_t csrAddrReg,
	input logic csrWeReg,
	input logic ecallReg, illegalReg,
	input logic mretReg, sretReg, uretReg,
	input word_t aluRes,
	input word_t csrNew,
	input word_t csrOld,
	output regAddr_t rdOut,
	output logic weOut,
	output word_t wbData,
	output word_t pcOut,
	output word_t csrWb,	// value for the csr file
	output csrAddr_t csrWbAddr,
	output logic csrWeOut,
	output logic ecall6, illegal6,
	output logic mretOut, sretOut, uretOut
);

	wbSel_t wbSel6;
	word_t aluRes6;
	word_t uImm6;
	word_t auipc6;
	word_t csrOld6;	// goes to rd on csr ops

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			{rdOut, weOut, wbSel6, pcOut, aluRes6, uImm6, auipc6} <= '0;
			{csrOld6, csrWb, csrWbAddr, csrWeOut} <= '0;
			{ecall6, illegal6, mretOut, sretOut, uretOut} <= '0;
		end
		else
		begin
			pcOut <= pcReg;	// survives flush, names the killed instruction
			rdOut <= flush ? '0 : rdReg;
			weOut <= flush ? 1'b0 : weReg;
			wbSel6 <= flush ? '0 : wbSelReg;
			aluRes6 <= flush ? '0 : aluRes;
			uImm6 <= flush ? '0 : uImmReg;
			auipc6 <= flush ? '0 : pcReg + uImmReg;
			csrOld6 <= flush ? '0 : csrOld;
			csrWb <= flush ? '0 : csrNew;
			csrWbAddr <= flush ? '0 : csrAddrReg;
			csrWeOut <= flush ? 1'b0 : csrWeReg;
			ecall6 <= flush ? 1'b0 : ecallReg;
			illegal6 <= flush ? 1'b0 : illegalReg;
			mretOut <= flush ? 1'b0 : mretReg;
			sretOut <= flush ? 1'b0 : sretReg;
			uretOut <= flush ? 1'b0 : uretReg;
		end
	end

	always_comb
	begin
		case (wbSel6)
			WB_ALU: wbData = aluRes6;
			WB_LINK: wbData = pcOut + 32'd4;
			WB_UIMM: wbData = uImm6;
			WB_AUIPC: wbData = auipc6;
			WB_CSR: wbData = csrOld6;
			default: wbData = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/exeIssueLatch.sv ====
`default_nettype none

module exeIssueLatch import rv32Pkg::*, trapPkg::*;
(
	input logic clk,
	input logic nrst,
	input logic flush,	// trap in commit kills the next instruction
	input word_t opA, opB, pc,
	input word_t bImm, jImm, uImm,
	input csrImm_t csrImm,
	input word_t csrData,
	input regAddr_t rd,
	input logic we,
	input aluOp_t aluOp,
	input wbSel_t wbSel,
	input csrOp_t csrOp,
	input csrAddr_t csrAddr,
	input logic csrWe,
	input logic isBranch, branchNe, isJal, isJalr,
	input logic ecall, illegal, mret, sret, uret,
	output word_t opAReg, opBReg, pcReg,
	output word_t bImmReg, jImmReg, uImmReg,
	output csrImm_t csrImmReg,
	output word_t csrDataReg,
	output regAddr_t rdReg,
	output logic weReg,
	output aluOp_t aluOpReg,
	output wbSel_t wbSelReg,
	output csrOp_t csrOpReg,
	output csrAddr_t csrAddrReg,
	output logic csrWeReg,
	output logic isBranchReg, branchNeReg, isJalReg, isJalrReg,
	output logic ecallReg, illegalReg, mretReg, sretReg, uretReg
);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			{opAReg, opBReg, pcReg, bImmReg, jImmReg, uImmReg} <= '0;
			{csrImmReg, csrDataReg, rdReg, weReg, aluOpReg, wbSelReg} <= '0;
			{csrOpReg, csrAddrReg, csrWeReg} <= '0;
			{isBranchReg, branchNeReg, isJalReg, isJalrReg} <= '0;
			{ecallReg, illegalReg, mretReg, sretReg, uretReg} <= '0;
		end
		else
		begin
			// a flushed slot becomes an all-zero bubble
			opAReg <= flush ? '0 : opA;
			opBReg <= flush ? '0 : opB;
			pcReg <= flush ? '0 : pc;
			bImmReg <= flush ? '0 : bImm;
			jImmReg <= flush ? '0 : jImm;
			uImmReg <= flush ? '0 : uImm;
			csrImmReg <= flush ? '0 : csrImm;
			csrDataReg <= flush ? '0 : csrData;
			rdReg <= flush ? '0 : rd;
			weReg <= flush ? 1'b0 : we;
			aluOpReg <= flush ? '0 : aluOp;
			wbSelReg <= flush ? '0 : wbSel;
			csrOpReg <= flush ? '0 : csrOp;
			csrAddrReg <= flush ? '0 : csrAddr;
			csrWeReg <= flush ? 1'b0 : csrWe;
			isBranchReg <= flush ? 1'b0 : isBranch;
			branchNeReg <= flush ? 1'b0 : branchNe;
			isJalReg <= flush ? 1'b0 : isJal;
			isJalrReg <= flush ? 1'b0 : isJalr;
			ecallReg <= flush ? 1'b0 : ecall;
			illegalReg <= flush ? 1'b0 : illegal;
			mretReg <= flush ? 1'b0 : mret;
			sretReg <= flush ? 1'b0 : sret;
			uretReg <= flush ? 1'b0 : uret;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/exeStage.sv ====
`default_nettype none

module exeStage import rv32Pkg::*, trapPkg::*;
(
	input logic clk,
	input logic nrst,
	input word_t opA, opB, pc,
	input word_t bImm, jImm, uImm,
	input csrImm_t csrImm,
	input word_t csrData,	// csr value read at issue
	input regAddr_t rd,
	input logic we,
	input aluOp_t aluOp,
	input wbSel_t wbSel,
	input csrOp_t csrOp,
	input csrAddr_t csrAddr,
	input logic csrWe,
	input logic isBranch, branchNe, isJal, isJalr,
	input logic ecall, illegal, mret, sret, uret,
	input logic mTimer, sTimer, extIrq,
	input logic mTie, sTie, mEie, sEie,
	input mode_t curMode,
	output logic bjTaken,
	output word_t target,
	output word_t wbData,
	output regAddr_t rdOut,
	output logic weOut,
	output word_t pcOut,
	output word_t csrWb,
	output csrAddr_t csrWbAddr,
	output logic csrWeOut,
	output logic mretOut, sretOut, uretOut,
	output logic exception,
	output cause_t cause
);

	// stage 5
	word_t opAReg, opBReg, pcReg, bImmReg, jImmReg, uImmReg, csrDataReg;
	csrImm_t csrImmReg;
	regAddr_t rdReg;
	logic weReg;
	aluOp_t aluOpReg;
	wbSel_t wbSelReg;
	csrOp_t csrOpReg;
	csrAddr_t csrAddrReg;
	logic csrWeReg;
	logic isBranchReg, branchNeReg, isJalReg, isJalrReg;
	logic ecallReg, illegalReg, mretReg, sretReg, uretReg;
	word_t aluRes;
	word_t csrNew;

	// stage 6 trap flags
	logic ecall6, illegal6;

	exeIssueLatch issueLatch (
		.clk, .nrst, .flush(exception),
		.opA, .opB, .pc, .bImm, .jImm, .uImm, .csrImm, .csrData,
		.rd, .we, .aluOp, .wbSel, .csrOp, .csrAddr, .csrWe,
		.isBranch, .branchNe, .isJal, .isJalr,
		.ecall, .illegal, .mret, .sret, .uret,
		.opAReg, .opBReg, .pcReg, .bImmReg, .jImmReg, .uImmReg,
		.csrImmReg, .csrDataReg,
		.rdReg, .weReg, .aluOpReg, .wbSelReg, .csrOpReg, .csrAddrReg, .csrWeReg,
		.isBranchReg, .branchNeReg, .isJalReg, .isJalrReg,
		.ecallReg, .illegalReg, .mretReg, .sretReg, .uretReg
	);

	exeAlu alu (
		.aluOp(aluOpReg), .opA(opAReg), .opB(opBReg),
		.pc(pcReg), .bImm(bImmReg), .jImm(jImmReg),
		.isBranch(isBranchReg), .branchNe(branchNeReg),
		.isJal(isJalReg), .isJalr(isJalrReg),
		.aluRes, .bjTaken, .target
	);

	csrModify csrUnit (
		.csrOp(csrOpReg),
		.rs1Val(opAReg),
		.csrImm(csrImmReg),
		.csrOld(csrDataReg),
		.csrNew
	);

	exeCommit commit (
		.clk, .nrst, .flush(exception),
		.rdReg, .weReg, .wbSelReg, .pcReg, .uImmReg, .csrAddrReg, .csrWeReg,
		.ecallReg, .illegalReg, .mretReg, .sretReg, .uretReg,
		.aluRes, .csrNew, .csrOld(csrDataReg),
		.rdOut, .weOut, .wbData, .pcOut,
		.csrWb, .csrWbAddr, .csrWeOut,
		.ecall6, .illegal6, .mretOut, .sretOut, .uretOut
	);

	trapDetect trap (
		.ecall6, .illegal6,
		.mret6(mretOut), .sret6(sretOut), .uret6(uretOut),
		.curMode, .mTimer, .sTimer, .extIrq,
		.mTie, .sTie, .mEie, .sEie,
		.exception, .cause
	);

endmodule

`default_nettype wire

// ==== verilog/rv32Pkg.sv ====
`default_nettype none

package rv32Pkg;

	typedef logic [31:0] word_t;	// data or address
	typedef logic [4:0] regAddr_t;
	typedef logic [4:0] csrImm_t;	// uimm field of the csr*i forms
	typedef logic [3:0] aluOp_t;
	typedef logic [2:0] wbSel_t;
	typedef logic [2:0] csrOp_t;	// funct3 of the SYSTEM opcode

	// alu ops
	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_SLL = 4'd2;
	localparam aluOp_t ALU_SLT = 4'd3;
	localparam aluOp_t ALU_SLTU = 4'd4;
	localparam aluOp_t ALU_XOR = 4'd5;
	localparam aluOp_t ALU_SRL = 4'd6;
	localparam aluOp_t ALU_SRA = 4'd7;
	localparam aluOp_t ALU_OR = 4'd8;
	localparam aluOp_t ALU_AND = 4'd9;

	// compares, result 0 or 1, also feed the branch condition
	localparam aluOp_t ALU_EQ = 4'd10;
	localparam aluOp_t ALU_LT = 4'd11;
	localparam aluOp_t ALU_LTU = 4'd12;

	// writeback source
	localparam wbSel_t WB_ALU = 3'd0;
	localparam wbSel_t WB_LINK = 3'd1;	// pc+4
	localparam wbSel_t WB_UIMM = 3'd2;	// lui
	localparam wbSel_t WB_AUIPC = 3'd3;	// pc+uImm
	localparam wbSel_t WB_CSR = 3'd4;	// old csr value

	localparam csrOp_t CSR_RW = 3'd1;
	localparam csrOp_t CSR_RS = 3'd2;
	localparam csrOp_t CSR_RC = 3'd3;
	localparam csrOp_t CSR_RWI = 3'd5;
	localparam csrOp_t CSR_RSI = 3'd6;
	localparam csrOp_t CSR_RCI = 3'd7;

endpackage

`default_nettype wire

// ==== verilog/trapDetect.sv ====
`default_nettype none

module trapDetect import trapPkg::*;
(
	input logic ecall6, illegal6,
	input logic mret6, sret6, uret6,
	input mode_t curMode,
	input logic mTimer, sTimer, extIrq,	// live pending lines
	input logic mTie, sTie, mEie, sEie,
	output logic exception,
	output cause_t cause
);

	logic sModeOk;
	logic mTimerOn, sTimerOn;
	logic mExtOn, sExtOn;
	logic anyIrq;

	// supervisor interrupts are not taken from M mode
	assign sModeOk = (curMode == MODE_U) || (curMode == MODE_S);

	assign mTimerOn = mTie && mTimer;
	assign sTimerOn = sModeOk && sTie && sTimer;
	assign mExtOn = mEie && extIrq;
	assign sExtOn = sModeOk && sEie && extIrq;
	assign anyIrq = mTimerOn || sTimerOn || mExtOn || sExtOn;

	// returns flush too, so the pc redirect lines up with the trap path
	assign exception = anyIrq || ecall6 || illegal6 || mret6 || sret6 || uret6;

	always_comb
	begin
		cause = '0;
		if (mExtOn)
			cause = CAUSE_M_EXT;
		else if (sExtOn)
			cause = CAUSE_S_EXT;
		else if (mTimerOn)
			cause = CAUSE_M_TIMER;
		else if (sTimerOn)
			cause = CAUSE_S_TIMER;
		else if (ecall6)
			cause = CAUSE_U_CALL + cause_t'(curMode);
		else if (illegal6)
			cause = CAUSE_ILLEGAL;
		cause[CAUSE_INT_BIT] = anyIrq;
	end

endmodule

`default_nettype wire

// ==== verilog/trapPkg.sv ====
`default_nettype none

package trapPkg;

	typedef logic [1:0] mode_t;	// privilege level
	typedef logic [11:0] csrAddr_t;
	typedef logic [31:0] cause_t;	// mcause layout

	localparam mode_t MODE_U = 2'd0;
	localparam mode_t MODE_S = 2'd1;
	localparam mode_t MODE_M = 2'd3;

	// interrupt codes, used with the interrupt bit set
	localparam cause_t CAUSE_S_TIMER = 32'd5;
	localparam cause_t CAUSE_M_TIMER = 32'd7;
	localparam cause_t CAUSE_S_EXT = 32'd9;
	localparam cause_t CAUSE_M_EXT = 32'd11;

	// synchronous exceptions
	localparam cause_t CAUSE_ILLEGAL = 32'd2;
	localparam cause_t CAUSE_U_CALL = 32'd8;	// plus current mode for S and M calls

	localparam int CAUSE_INT_BIT = 31;

endpackage

`default_nettype wire
